// File: source/store_pkg.sv
/*
  Shared widths, depths and payload types of the store buffer.
  Both queue depths must be powers of two because the pointers wrap by overflow.
*/
package store_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------

    // physical address width
    localparam int unsigned PLEN = 34;
    // data width of one store
    localparam int unsigned XLEN = 64;
    // one enable per data byte
    localparam int unsigned BE_W = XLEN / 8;
    // load offset as seen by the checker, one page
    localparam int unsigned PAGE_OFFSET_W = 12;

    // compared offset bits, doubleword granularity inside the page
    localparam int unsigned OFFSET_LSB = 3;
    localparam int unsigned OFFSET_MSB = 11;

    // ------------------------------------------------------------
    // depths and credits
    // ------------------------------------------------------------

    localparam int unsigned DEPTH_SPEC   = 4;
    localparam int unsigned DEPTH_COMMIT = 4;

    // writes the memory side can absorb before returning credits
    localparam int unsigned MEM_CREDITS = 2;

    // pointer and counter widths, counters need one extra state for "full"
    localparam int unsigned SPEC_PTR_W   = $clog2(DEPTH_SPEC);
    localparam int unsigned SPEC_CNT_W   = $clog2(DEPTH_SPEC + 1);
    localparam int unsigned COMMIT_PTR_W = $clog2(DEPTH_COMMIT);
    localparam int unsigned COMMIT_CNT_W = $clog2(DEPTH_COMMIT + 1);
    localparam int unsigned CREDIT_W     = $clog2(MEM_CREDITS + 1);

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------

    // access size opcode
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10,
        SIZE_D = 2'b11
    } size_e;

    // payload of one store as handed in by the LSU
    typedef struct packed {
        logic [PLEN-1:0] addr;
        logic [XLEN-1:0] data;
        logic [BE_W-1:0] be;
        size_e           size;
    } store_t;

    // one write on the memory port
    typedef struct packed {
        logic [PLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [BE_W-1:0] be;
        size_e           size;
    } mem_wr_t;

    // queue slot, payload plus occupancy flag
    typedef struct packed {
        store_t st;
        logic   valid;
    } entry_t;

endpackage

// File: source/store_ctrl.sv
/*
  Occupancy and credit bookkeeping for both store queues.
  A flush together with a push drops the pushed store as well.
*/
module store_ctrl (
    input  logic clk_i,
    input  logic rst_ni,

    // LSU side
    input  logic st_valid_i,
    output logic st_ready_o,

    // commit and flush from the issue stage
    input  logic commit_i,
    output logic commit_ready_o,
    input  logic flush_i,

    // memory credit return
    input  logic mem_credit_i,

    // queue enables
    output logic spec_push_o,
    output logic spec_pop_o,
    output logic spec_flush_o,
    output logic commit_push_o,
    output logic mem_send_o,

    // status
    output logic no_st_pending_o,
    output logic empty_o
);

    import store_pkg::*;

    logic [SPEC_CNT_W-1:0]   spec_cnt_d, spec_cnt_q;
    logic [COMMIT_CNT_W-1:0] commit_cnt_d, commit_cnt_q;
    logic [CREDIT_W-1:0]     credit_cnt_d, credit_cnt_q;

    // ------------------------------------------------------------
    // handshakes and enables
    // ------------------------------------------------------------

    // ready only looks at the speculative count
    assign st_ready_o     = (spec_cnt_q < DEPTH_SPEC);
    assign commit_ready_o = (commit_cnt_q < DEPTH_COMMIT);

    assign spec_push_o  = st_valid_i & st_ready_o;
    // a commit moves the speculative head into the commit queue
    assign spec_pop_o    = commit_i;
    assign commit_push_o = commit_i;
    assign spec_flush_o  = flush_i;

    // send whenever something is committed and a credit is left
    assign mem_send_o = (commit_cnt_q != '0) && (credit_cnt_q != '0);

    assign no_st_pending_o = (commit_cnt_q == '0);
    assign empty_o         = (spec_cnt_q == '0) && no_st_pending_o;

    // ------------------------------------------------------------
    // next counts
    // ------------------------------------------------------------

    always_comb begin
        spec_cnt_d = spec_cnt_q;
        if (flush_i) begin
            // every speculative store is discarded
            spec_cnt_d = '0;
        end else if (spec_push_o && !spec_pop_o) begin
            spec_cnt_d = spec_cnt_q + SPEC_CNT_W'(1);
        end else if (!spec_push_o && spec_pop_o) begin
            spec_cnt_d = spec_cnt_q - SPEC_CNT_W'(1);
        end
    end

    always_comb begin
        commit_cnt_d = commit_cnt_q;
        // committed stores survive a flush
        if (commit_push_o && !mem_send_o) begin
            commit_cnt_d = commit_cnt_q + COMMIT_CNT_W'(1);
        end else if (!commit_push_o && mem_send_o) begin
            commit_cnt_d = commit_cnt_q - COMMIT_CNT_W'(1);
        end
    end

    always_comb begin
        credit_cnt_d = credit_cnt_q;
        // spend one per send, regain one per returned pulse
        if (mem_send_o && !mem_credit_i) begin
            credit_cnt_d = credit_cnt_q - CREDIT_W'(1);
        end else if (!mem_send_o && mem_credit_i) begin
            credit_cnt_d = credit_cnt_q + CREDIT_W'(1);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            spec_cnt_q   <= '0;
            commit_cnt_q <= '0;
            credit_cnt_q <= CREDIT_W'(MEM_CREDITS);
        end else begin
            spec_cnt_q   <= spec_cnt_d;
            commit_cnt_q <= commit_cnt_d;
            credit_cnt_q <= credit_cnt_d;
        end
    end

    // ------------------------------------------------------------
    // protocol checks
    // ------------------------------------------------------------

    // flush and commit come from the same stage and exclude each other
    a_commit_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !commit_i)
        else $error("commit and flush raised in the same cycle");

    a_spec_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (spec_cnt_q == '0) |-> !commit_i)
        else $error("commit with no speculative store");

    a_commit_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_cnt_q == DEPTH_COMMIT) |-> !commit_i)
        else $error("commit into a full commit queue");

    // a credit while all credits are home means the memory side miscounted
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_credit_i && !mem_send_o |=> credit_cnt_q <= MEM_CREDITS)
        else $error("credit count above MEM_CREDITS");

endmodule

// File: source/spec_queue.sv
/*
  Circular buffer of stores that can still be flushed.
  Payload slots have no reset, only the valid bits and pointers do.
*/
module spec_queue (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          push_i,
    input  logic                                          pop_i,
    input  logic                                          flush_i,
    input  store_pkg::store_t                             st_i,
    output store_pkg::entry_t                             head_o,
    output store_pkg::entry_t [store_pkg::DEPTH_SPEC-1:0] entries_o
);

    import store_pkg::*;

    store_t                 mem_q [DEPTH_SPEC];
    logic [DEPTH_SPEC-1:0]  valid_q;
    logic [SPEC_PTR_W-1:0]  rd_ptr_q, wr_ptr_q;

    // ------------------------------------------------------------
    // read side
    // ------------------------------------------------------------

    // oldest store, taken by the commit queue on a commit
    assign head_o.st    = mem_q[rd_ptr_q];
    assign head_o.valid = valid_q[rd_ptr_q];

    // whole array for the offset checker
    always_comb begin
        for (int unsigned i = 0; i < DEPTH_SPEC; i++) begin
            entries_o[i].st    = mem_q[i];
            entries_o[i].valid = valid_q[i];
        end
    end

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    // payload is written on every push, flushed slots are simply overwritten later
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= st_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
        end else if (flush_i) begin
            // drop everything speculative, a push in the same cycle is lost too
            valid_q  <= '0;
            wr_ptr_q <= rd_ptr_q;
        end else begin
            if (push_i) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= wr_ptr_q + SPEC_PTR_W'(1);
            end
            // head leaves for the commit queue
            if (pop_i) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q          <= rd_ptr_q + SPEC_PTR_W'(1);
            end
        end
    end

    // the control count and the valid bits must agree on a commit
    a_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> head_o.valid)
        else $error("commit of an invalid speculative head");

    // overflow shows up as a push onto a slot that is still occupied
    a_push_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !valid_q[wr_ptr_q])
        else $error("push into an occupied speculative slot");

endmodule

// File: source/commit_queue.sv
/*
  Circular buffer of committed stores, drained in order to the memory port.
  Flush has no effect here, committed stores always reach memory.
*/
module commit_queue (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,
    input  logic                                            push_i,
    input  logic                                            pop_i,
    input  store_pkg::entry_t                               entry_i,
    output store_pkg::mem_wr_t                              mem_wr_o,
    output store_pkg::entry_t [store_pkg::DEPTH_COMMIT-1:0] entries_o
);

    import store_pkg::*;

    store_t                  mem_q [DEPTH_COMMIT];
    logic [DEPTH_COMMIT-1:0] valid_q;
    logic [COMMIT_PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    store_t                  head;

    // ------------------------------------------------------------
    // memory write from the head
    // ------------------------------------------------------------

    assign head = mem_q[rd_ptr_q];

    // field renaming only, the write is qualified by the control's send
    assign mem_wr_o.addr  = head.addr;
    assign mem_wr_o.wdata = head.data;
    assign mem_wr_o.be    = head.be;
    assign mem_wr_o.size  = head.size;

    always_comb begin
        for (int unsigned i = 0; i < DEPTH_COMMIT; i++) begin
            entries_o[i].st    = mem_q[i];
            entries_o[i].valid = valid_q[i];
        end
    end

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= entry_i.st;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
        end else begin
            // speculative head carries its own valid
            if (push_i) begin
                valid_q[wr_ptr_q] <= entry_i.valid;
                wr_ptr_q          <= wr_ptr_q + COMMIT_PTR_W'(1);
            end
            // sent means done, no acknowledge
            if (pop_i) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q          <= rd_ptr_q + COMMIT_PTR_W'(1);
            end
        end
    end

    // a send must never carry an empty slot to memory
    a_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> valid_q[rd_ptr_q])
        else $error("memory write from an invalid commit head");

endmodule

// File: source/offset_checker.sv
/*
  Purely combinational, compares doubleword offsets inside a page only.
  A hit tells the load side to wait, it does not forward data.
*/
module offset_checker (
    input  logic [store_pkg::PAGE_OFFSET_W-1:0]             ld_offset_i,
    input  store_pkg::entry_t [store_pkg::DEPTH_SPEC-1:0]   spec_entries_i,
    input  store_pkg::entry_t [store_pkg::DEPTH_COMMIT-1:0] commit_entries_i,
    input  logic                                            st_valid_i,
    input  logic [store_pkg::PLEN-1:0]                      st_addr_i,
    output logic                                            match_o
);

    import store_pkg::*;

    logic [OFFSET_MSB:OFFSET_LSB] ld_off;
    logic                         spec_hit, commit_hit, in_hit;

    assign ld_off = ld_offset_i[OFFSET_MSB:OFFSET_LSB];

    // any valid speculative entry with the same offset
    always_comb begin
        spec_hit = 1'b0;
        for (int unsigned i = 0; i < DEPTH_SPEC; i++) begin
            spec_hit |= spec_entries_i[i].valid &&
                        (spec_entries_i[i].st.addr[OFFSET_MSB:OFFSET_LSB] == ld_off);
        end
    end

    // same for the committed stores still waiting for memory
    always_comb begin
        commit_hit = 1'b0;
        for (int unsigned i = 0; i < DEPTH_COMMIT; i++) begin
            commit_hit |= commit_entries_i[i].valid &&
                          (commit_entries_i[i].st.addr[OFFSET_MSB:OFFSET_LSB] == ld_off);
        end
    end

    // store offered this cycle, whether or not it is accepted
    assign in_hit = st_valid_i && (st_addr_i[OFFSET_MSB:OFFSET_LSB] == ld_off);

    assign match_o = spec_hit | commit_hit | in_hit;

endmodule

// File: source/store_buffer_top.sv
/*
  Store buffer with a credit based memory port, a write counts as done once sent.
  commit_i needs a speculative store and commit_ready_o, and never comes with flush_i.
*/
module store_buffer_top (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    // store input
    input  logic                                st_valid_i,
    input  store_pkg::store_t                   st_req_i,
    output logic                                st_ready_o,

    // commit and flush
    input  logic                                commit_i,
    output logic                                commit_ready_o,
    input  logic                                flush_i,

    // memory write port
    output logic                                mem_valid_o,
    output store_pkg::mem_wr_t                  mem_wr_o,
    input  logic                                mem_credit_i,

    // load offset check
    input  logic [store_pkg::PAGE_OFFSET_W-1:0] ld_offset_i,
    output logic                                offset_match_o,

    // status
    output logic                                no_st_pending_o,
    output logic                                empty_o
);

    import store_pkg::*;

    logic spec_push, spec_pop, spec_flush, commit_push, mem_send;

    entry_t                    spec_head;
    entry_t [DEPTH_SPEC-1:0]   spec_entries;
    entry_t [DEPTH_COMMIT-1:0] commit_entries;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------

    store_ctrl i_store_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .st_valid_i      (st_valid_i),
        .st_ready_o      (st_ready_o),
        .commit_i        (commit_i),
        .commit_ready_o  (commit_ready_o),
        .flush_i         (flush_i),
        .mem_credit_i    (mem_credit_i),
        .spec_push_o     (spec_push),
        .spec_pop_o      (spec_pop),
        .spec_flush_o    (spec_flush),
        .commit_push_o   (commit_push),
        .mem_send_o      (mem_send),
        .no_st_pending_o (no_st_pending_o),
        .empty_o         (empty_o)
    );

    // ------------------------------------------------------------
    // queues and checker
    // ------------------------------------------------------------

    spec_queue i_spec_queue (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push_i    (spec_push),
        .pop_i     (spec_pop),
        .flush_i   (spec_flush),
        .st_i      (st_req_i),
        .head_o    (spec_head),
        .entries_o (spec_entries)
    );

    // a send pops the commit head
    commit_queue i_commit_queue (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .push_i    (commit_push),
        .pop_i     (mem_send),
        .entry_i   (spec_head),
        .mem_wr_o  (mem_wr_o),
        .entries_o (commit_entries)
    );

    offset_checker i_offset_checker (
        .ld_offset_i      (ld_offset_i),
        .spec_entries_i   (spec_entries),
        .commit_entries_i (commit_entries),
        .st_valid_i       (st_valid_i),
        .st_addr_i        (st_req_i.addr),
        .match_o          (offset_match_o)
    );

    assign mem_valid_o = mem_send;

endmodule

// File: verification/store_buffer_model.svh
/*
  Reference model of the store buffer, included inside the testbench module.
  Needs store_pkg imported before the include and one update per rising edge.
*/
`ifndef STORE_BUFFER_MODEL_SVH
`define STORE_BUFFER_MODEL_SVH

// ------------------------------------------------------------
// model state
// ------------------------------------------------------------

// stores that a flush can still drop, oldest first
store_t      spec_m[$];
// committed stores in memory order
store_t      commit_m[$];
// credits the sender still holds
int unsigned credit_m = MEM_CREDITS;
// commits seen since reset
int unsigned commit_total = 0;

// ------------------------------------------------------------
// expected values
// ------------------------------------------------------------

// oldest committed store renamed into a memory write
function automatic mem_wr_t expected_write();
    mem_wr_t wr;
    wr.addr  = commit_m[0].addr;
    wr.wdata = commit_m[0].data;
    wr.be    = commit_m[0].be;
    wr.size  = commit_m[0].size;
    return wr;
endfunction

// doubleword inside the page, bits 11 to 3
function automatic logic same_offset(input logic [PLEN-1:0]          addr,
                                     input logic [PAGE_OFFSET_W-1:0] off);
    return addr[11:3] == off[11:3];
endfunction

// any buffered store or the offered one blocks the load
function automatic logic expected_match(input logic [PAGE_OFFSET_W-1:0] off,
                                        input logic                     st_valid,
                                        input logic [PLEN-1:0]          st_addr);
    logic hit;
    hit = st_valid && same_offset(st_addr, off);
    foreach (spec_m[i]) begin
        hit = hit | same_offset(spec_m[i].addr, off);
    end
    // committed but not yet sent still counts
    foreach (commit_m[i]) begin
        hit = hit | same_offset(commit_m[i].addr, off);
    end
    return hit;
endfunction

// ------------------------------------------------------------
// state update at a rising edge
// ------------------------------------------------------------

task automatic model_step(input logic accept, input logic commit, input logic flush,
                          input logic send, input logic credit, input store_t st);
    store_t head;
    // the sent head leaves before a commit lands behind it
    if (send) begin
        head = commit_m.pop_front();
    end
    if (flush) begin
        // an offered store is lost together with the flush
        spec_m.delete();
    end else begin
        if (commit) begin
            head = spec_m.pop_front();
            commit_m.push_back(head);
            commit_total++;
        end
        if (accept) begin
            spec_m.push_back(st);
        end
    end
    // one credit out per send, one back per pulse
    if (send && !credit) begin
        credit_m--;
    end else if (credit && !send) begin
        credit_m++;
    end
endtask

`endif

// File: verification/store_buffer_tb.sv
/*
  Self-checking testbench, credits come back from a small memory model.
  The first mismatch or timeout ends the run.
*/
module store_buffer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import store_pkg::*;

    localparam int unsigned N_RANDOM   = 400;
    localparam int unsigned WAIT_LIMIT = 200;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     st_valid_i;
    store_t                   st_req_i;
    logic                     st_ready_o;
    logic                     commit_i;
    logic                     commit_ready_o;
    logic                     flush_i;
    logic                     mem_valid_o;
    mem_wr_t                  mem_wr_o;
    logic                     mem_credit_i;
    logic [PAGE_OFFSET_W-1:0] ld_offset_i;
    logic                     offset_match_o;
    logic                     no_st_pending_o;
    logic                     empty_o;

    integer      seed = 79603;
    // memory side stops returning credits while set
    logic        credit_hold;
    int unsigned mem_cycle = 0;
    int unsigned wr_count = 0;
    // cycle at which each outstanding credit goes back
    int unsigned due_q[$];

    `include "store_buffer_model.svh"

    store_buffer_top i_store_buffer_top (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .st_valid_i      (st_valid_i),
        .st_req_i        (st_req_i),
        .st_ready_o      (st_ready_o),
        .commit_i        (commit_i),
        .commit_ready_o  (commit_ready_o),
        .flush_i         (flush_i),
        .mem_valid_o     (mem_valid_o),
        .mem_wr_o        (mem_wr_o),
        .mem_credit_i    (mem_credit_i),
        .ld_offset_i     (ld_offset_i),
        .offset_match_o  (offset_match_o),
        .no_st_pending_o (no_st_pending_o),
        .empty_o         (empty_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_write(input mem_wr_t got, input mem_wr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR mem_wr_o got %h exp %h", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    task automatic check_store_cnt(input string name, input int unsigned got,
                                   input int unsigned exp);
        if (got != exp) begin
            report_failure($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    // pre-edge values against the model, then advance the model
    always @(posedge clk_i) begin
        if (rst_ni) begin
            check_flag("st_ready_o", st_ready_o, spec_m.size() < DEPTH_SPEC);
            check_flag("commit_ready_o", commit_ready_o, commit_m.size() < DEPTH_COMMIT);
            check_flag("mem_valid_o", mem_valid_o, commit_m.size() != 0 && credit_m != 0);
            check_flag("no_st_pending_o", no_st_pending_o, commit_m.size() == 0);
            check_flag("empty_o", empty_o, spec_m.size() == 0 && commit_m.size() == 0);
            check_flag("offset_match_o", offset_match_o,
                       expected_match(ld_offset_i, st_valid_i, st_req_i.addr));
            if (mem_valid_o) begin
                check_write(mem_wr_o, expected_write());
            end
            model_step(st_valid_i && st_ready_o, commit_i, flush_i, mem_valid_o,
                       mem_credit_i, st_req_i);
        end
    end

    // ------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------

    // every received write owes one credit after 0 to 5 cycles
    always @(posedge clk_i) begin
        mem_cycle++;
        if (rst_ni && mem_valid_o) begin
            wr_count++;
            due_q.push_back(mem_cycle + ($unsigned($random(seed)) % 6));
        end
    end

    initial begin
        int unsigned drop;
        mem_credit_i = 1'b0;
        forever begin
            @(negedge clk_i);
            mem_credit_i = 1'b0;
            // at most one pulse per cycle
            if (!credit_hold && due_q.size() != 0 && due_q[0] <= mem_cycle) begin
                drop         = due_q.pop_front();
                mem_credit_i = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    function automatic store_t random_store();
        store_t     st;
        logic [1:0] sz;
        st.addr = PLEN'({$random(seed), $random(seed)});
        st.data = {$random(seed), $random(seed)};
        st.be   = BE_W'($random(seed));
        sz      = 2'($random(seed));
        st.size = size_e'(sz);
        return st;
    endfunction

    // commit needs a speculative store and room behind it
    function automatic logic can_commit();
        return spec_m.size() != 0 && commit_m.size() < DEPTH_COMMIT;
    endfunction

    task automatic drive_idle();
        st_valid_i = 1'b0;
        commit_i   = 1'b0;
        flush_i    = 1'b0;
    endtask

    task automatic random_cycle();
        int unsigned r;
        r = $unsigned($random(seed)) % 16;
        drive_idle();
        st_valid_i = ($random(seed) & 3) != 0;
        st_req_i   = random_store();
        if (r == 0) begin
            flush_i = 1'b1;
        end else if (r < 9 && can_commit()) begin
            commit_i = 1'b1;
        end
        // aim the load at the offered store half of the time
        if (($random(seed) & 1) != 0) begin
            ld_offset_i = st_req_i.addr[PAGE_OFFSET_W-1:0];
        end else begin
            ld_offset_i = PAGE_OFFSET_W'($random(seed));
        end
    endtask

    // commit what is left and wait for memory and credits to settle
    task automatic drain_all();
        int unsigned waited;
        waited      = 0;
        credit_hold = 1'b0;
        while (!(no_st_pending_o && empty_o && credit_m == MEM_CREDITS)) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("timeout: buffer never drained with all credits back");
            end
            drive_idle();
            commit_i = can_commit();
            @(negedge clk_i);
            waited++;
        end
        drive_idle();
    endtask

    initial begin
        int unsigned waited;
        int unsigned base;
        int unsigned first_commit;
        store_t      st;
        rst_ni      = 1'b0;
        credit_hold = 1'b0;
        st_req_i    = '0;
        ld_offset_i = '0;
        drive_idle();
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;

        // reset state, then one store with the write one cycle after its commit
        check_flag("st_ready_o", st_ready_o, 1'b1);
        check_flag("commit_ready_o", commit_ready_o, 1'b1);
        check_flag("mem_valid_o", mem_valid_o, 1'b0);
        check_flag("no_st_pending_o", no_st_pending_o, 1'b1);
        check_flag("offset_match_o", offset_match_o, 1'b0);
        st_valid_i = 1'b1;
        st_req_i   = random_store();
        @(negedge clk_i);
        st_valid_i = 1'b0;
        commit_i   = 1'b1;
        @(negedge clk_i);
        commit_i = 1'b0;
        check_flag("mem_valid_o", mem_valid_o, 1'b1);
        check_write(mem_wr_o, expected_write());
        drain_all();

        // random stores, commits and flushes
        for (int unsigned i = 0; i < N_RANDOM; i++) begin
            random_cycle();
            @(negedge clk_i);
        end
        drain_all();

        // no credits: two writes leave, then the commit queue fills
        credit_hold  = 1'b1;
        base         = wr_count;
        first_commit = commit_total;
        waited       = 0;
        while (commit_total - first_commit < MEM_CREDITS + DEPTH_COMMIT) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("timeout: commit queue never filled without credits");
            end
            drive_idle();
            st_valid_i = 1'b1;
            st_req_i   = random_store();
            commit_i   = can_commit();
            @(negedge clk_i);
            waited++;
        end
        drive_idle();
        repeat (4) @(negedge clk_i);
        check_flag("commit_ready_o", commit_ready_o, 1'b0);
        check_flag("mem_valid_o", mem_valid_o, 1'b0);
        check_store_cnt("writes without credit", wr_count - base, MEM_CREDITS);
        drain_all();

        // speculative queue full, flush restores ready
        waited = 0;
        while (st_ready_o) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("timeout: st_ready_o never fell with stores pending");
            end
            drive_idle();
            st_valid_i = 1'b1;
            st_req_i   = random_store();
            @(negedge clk_i);
            waited++;
        end
        drive_idle();
        check_store_cnt("speculative stores", spec_m.size(), DEPTH_SPEC);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        check_flag("st_ready_o", st_ready_o, 1'b1);
        // with the speculative side gone only the commit queue decides
        check_flag("empty_o", empty_o, commit_m.size() == 0);
        check_flag("no_st_pending_o", no_st_pending_o, commit_m.size() == 0);

        // empty buffer, only the offered store can hit, the flush drops it
        st          = random_store();
        st_valid_i  = 1'b1;
        st_req_i    = st;
        flush_i     = 1'b1;
        ld_offset_i = st.addr[PAGE_OFFSET_W-1:0];
        #1;
        check_flag("offset_match_o", offset_match_o, 1'b1);
        @(negedge clk_i);
        drive_idle();
        #1;
        check_flag("offset_match_o", offset_match_o, 1'b0);

        // final drain, every commit reached memory
        drain_all();
        check_flag("no_st_pending_o", no_st_pending_o, 1'b1);
        check_flag("empty_o", empty_o, 1'b1);
        check_store_cnt("writes received", wr_count, commit_total);

        $display("all tests passed");
        $finish;
    end

endmodule

// File: build.f
+incdir+verification
source/store_pkg.sv
source/store_ctrl.sv
source/spec_queue.sv
source/commit_queue.sv
source/offset_checker.sv
source/store_buffer_top.sv
verification/store_buffer_tb.sv
